// ==== design/bridge_settings.svh ====
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// core and ARM physical addresses share one width
`define BRIDGE_ADDR_W 32

// host register words
`define BRIDGE_DATA_W 32

// the ARM window port drops the top two address bits
`define BRIDGE_WIN_ADDR_W 30

// core DRAM starts here and is XOR-ed away before the ARM base is added
`define BRIDGE_DRAM_BASE 32'h8000_0000

// offsets at or above 120 MiB are counted as out of range
`define BRIDGE_DRAM_LIMIT (32'd120 * 32'd1024 * 32'd1024)

// the profiler splits 1 GiB into 128 regions of 8 MiB
`define BRIDGE_REGION_MSB 29
`define BRIDGE_REGION_W 7

// word address of the host register block
`define BRIDGE_CSR_ADDR_W 3

`endif

// ==== design/bridge_pkg.sv ====
`include "bridge_settings.svh"

package bridge_pkg;

   typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;

   typedef logic [`BRIDGE_WIN_ADDR_W-1:0] win_addr_t;

   typedef logic [`BRIDGE_DATA_W-1:0] data_t;

   typedef logic [`BRIDGE_REGION_W-1:0] region_t;

   // one bit per region, grouped into words for the host read-back
   typedef logic [(1 << `BRIDGE_REGION_W) / `BRIDGE_DATA_W - 1:0][`BRIDGE_DATA_W-1:0] profile_t;

   // host register map, word addressed
   typedef enum logic [`BRIDGE_CSR_ADDR_W-1:0]
   {
      csr_ctrl      = 3'd0,
      csr_dram_base = 3'd1,
      csr_prof0     = 3'd2,
      csr_prof1     = 3'd3,
      csr_prof2     = 3'd4,
      csr_prof3     = 3'd5,
      csr_oob_count = 3'd6
   } csr_addr_e;

endpackage

// ==== design/dram_access_if.sv ====
// accepted core DRAM accesses, as seen by the profiler
interface dram_access_if;
   import bridge_pkg::*;

   // high for one cycle per accepted request
   logic    acc_fire;
   logic    acc_write;
   // 8 MiB region index taken from the core address
   region_t acc_region;
   // offset lies at or above the DRAM limit
   logic    acc_oob;

   modport src
   (
      output acc_fire,
      output acc_write,
      output acc_region,
      output acc_oob
   );

   modport dst
   (
      input acc_fire,
      input acc_write,
      input acc_region,
      input acc_oob
   );

endinterface

// ==== design/host_csr_regs.sv ====
`include "bridge_settings.svh"

module host_csr_regs
(
   input  logic                  aclk_i,
   input  logic                  arst_n_i,
   input  logic                  csr_req_valid_i,
   input  logic                  csr_req_write_i,
   input  bridge_pkg::csr_addr_e csr_req_addr_i,
   input  bridge_pkg::data_t     csr_req_wdata_i,
   input  bridge_pkg::profile_t  profile_i,
   input  bridge_pkg::data_t     oob_count_i,
   output logic                  csr_rsp_valid_o,
   output bridge_pkg::data_t     csr_rsp_rdata_o,
   output logic                  core_reset_o,
   output bridge_pkg::addr_t     dram_base_o
);
   import bridge_pkg::*;

   logic  run_q;
   addr_t dram_base_q;
   logic  rsp_valid_q;
   data_t rdata_q;
   data_t rdata_d;
   logic  wr_en;
   logic  rd_en;

   assign wr_en = csr_req_valid_i & csr_req_write_i;
   assign rd_en = csr_req_valid_i & ~csr_req_write_i;

   // only ctrl and the DRAM base take writes
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_q       <= 1'b0;
         dram_base_q <= '0;
      end
      else if (wr_en)
      begin
         case (csr_req_addr_i)
            csr_ctrl:      run_q       <= csr_req_wdata_i[0];
            csr_dram_base: dram_base_q <= csr_req_wdata_i;
            default:       ;
         endcase
      end
   end

   // unmapped words read as zero
   always_comb
   begin
      case (csr_req_addr_i)
         csr_ctrl:      rdata_d = {{(`BRIDGE_DATA_W-1){1'b0}}, run_q};
         csr_dram_base: rdata_d = dram_base_q;
         csr_prof0:     rdata_d = profile_i[0];
         csr_prof1:     rdata_d = profile_i[1];
         csr_prof2:     rdata_d = profile_i[2];
         csr_prof3:     rdata_d = profile_i[3];
         csr_oob_count: rdata_d = oob_count_i;
         default:       rdata_d = '0;
      endcase
   end

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         rsp_valid_q <= 1'b0;
      else
         rsp_valid_q <= rd_en;
   end

   always_ff @(posedge aclk_i)
   begin
      if (rd_en)
         rdata_q <= rdata_d;
   end

   assign csr_rsp_valid_o = rsp_valid_q;
   assign csr_rsp_rdata_o = rdata_q;

   // the run bit clears on reset, which keeps the core held
   assign core_reset_o = ~run_q;
   assign dram_base_o  = dram_base_q;

endmodule

// ==== design/host_window_xlate.sv ====
`include "bridge_settings.svh"

module host_window_xlate
(
   input  logic                  aclk_i,
   input  logic                  arst_n_i,
   input  logic                  win_valid_i,
   input  bridge_pkg::win_addr_t win_addr_i,
   input  logic                  core_ready_i,
   output logic                  win_ready_o,
   output logic                  core_valid_o,
   output bridge_pkg::addr_t     core_addr_o
);
   import bridge_pkg::*;

   localparam int PASS_W = `BRIDGE_ADDR_W - 4;

   logic  valid_q;
   addr_t addr_q;
   addr_t xlate_addr;
   logic  accept;

   // window 0x0xxx_xxxx maps to core DRAM at 0x8xxx_xxxx,
   // window 0x2xxx_xxxx maps to core local space at 0x0xxx_xxxx
   assign xlate_addr = {~win_addr_i[`BRIDGE_WIN_ADDR_W-1], 3'b000, win_addr_i[PASS_W-1:0]};

   // empty or draining this cycle
   assign win_ready_o = ~valid_q | core_ready_i;
   assign accept      = win_valid_i & win_ready_o;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         valid_q <= 1'b0;
      else if (accept)
         valid_q <= 1'b1;
      else if (core_ready_i)
         valid_q <= 1'b0;
   end

   always_ff @(posedge aclk_i)
   begin
      if (accept)
         addr_q <= xlate_addr;
   end

   assign core_valid_o = valid_q;
   assign core_addr_o  = addr_q;

endmodule

// ==== design/dram_rebase.sv ====
`include "bridge_settings.svh"

module dram_rebase
(
   input  logic              aclk_i,
   input  logic              arst_n_i,
   input  logic              dram_valid_i,
   input  logic              dram_write_i,
   input  bridge_pkg::addr_t dram_addr_i,
   input  bridge_pkg::addr_t dram_base_i,
   input  logic              mem_ready_i,
   output logic              dram_ready_o,
   output logic              mem_valid_o,
   output logic              mem_write_o,
   output bridge_pkg::addr_t mem_addr_o,
   dram_access_if.src        acc_o
);
   import bridge_pkg::*;

   logic  valid_q;
   logic  write_q;
   addr_t addr_q;
   addr_t offset;
   logic  accept;

   // XOR strips the core DRAM base bit and leaves the offset
   assign offset = dram_addr_i ^ `BRIDGE_DRAM_BASE;

   assign dram_ready_o = ~valid_q | mem_ready_i;
   assign accept       = dram_valid_i & dram_ready_o;

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         valid_q <= 1'b0;
      else if (accept)
         valid_q <= 1'b1;
      else if (mem_ready_i)
         valid_q <= 1'b0;
   end

   // the base is sampled together with the address it applies to
   always_ff @(posedge aclk_i)
   begin
      if (accept)
      begin
         addr_q  <= offset + dram_base_i;
         write_q <= dram_write_i;
      end
   end

   assign mem_valid_o = valid_q;
   assign mem_write_o = write_q;
   assign mem_addr_o  = addr_q;

   // report each accepted request to the profiler
   assign acc_o.acc_fire   = accept;
   assign acc_o.acc_write  = dram_write_i;
   assign acc_o.acc_region = dram_addr_i[`BRIDGE_REGION_MSB -: `BRIDGE_REGION_W];
   assign acc_o.acc_oob    = offset >= `BRIDGE_DRAM_LIMIT;

endmodule

// ==== design/mem_profiler.sv ====
module mem_profiler
(
   input  logic                 aclk_i,
   input  logic                 arst_n_i,
   input  logic                 core_reset_i,
   dram_access_if.dst           acc_i,
   output bridge_pkg::profile_t profile_o,
   output bridge_pkg::data_t    oob_count_o
);
   import bridge_pkg::*;

   localparam int PROF_W = $bits(profile_t);

   profile_t          prof_q;
   data_t             oob_q;
   logic [PROF_W-1:0] hit;

   // reads and writes both mark their region
   assign hit = PROF_W'(acc_i.acc_fire) << acc_i.acc_region;

   // sticky until the core is put back into reset
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         prof_q <= '0;
         oob_q  <= '0;
      end
      else if (core_reset_i)
      begin
         prof_q <= '0;
         oob_q  <= '0;
      end
      else
      begin
         prof_q <= prof_q | hit;
         // counter stops at all ones
         if (acc_i.acc_fire && acc_i.acc_oob && oob_q != '1)
            oob_q <= oob_q + 1'b1;
      end
   end

   assign profile_o   = prof_q;
   assign oob_count_o = oob_q;

endmodule

// ==== design/zynq_host_bridge.sv ====
`include "bridge_settings.svh"

module zynq_host_bridge
(
   input  logic                          aclk_i,
   input  logic                          arst_n_i,

   input  logic                          csr_req_valid_i,
   input  logic                          csr_req_write_i,
   input  logic [`BRIDGE_CSR_ADDR_W-1:0] csr_req_addr_i,
   input  bridge_pkg::data_t             csr_req_wdata_i,
   output logic                          csr_rsp_valid_o,
   output bridge_pkg::data_t             csr_rsp_rdata_o,

   output logic                          core_reset_o,

   input  logic                          win_valid_i,
   input  bridge_pkg::win_addr_t         win_addr_i,
   output logic                          win_ready_o,
   output logic                          core_valid_o,
   output bridge_pkg::addr_t             core_addr_o,
   input  logic                          core_ready_i,

   input  logic                          dram_valid_i,
   input  logic                          dram_write_i,
   input  bridge_pkg::addr_t             dram_addr_i,
   output logic                          dram_ready_o,
   output logic                          mem_valid_o,
   output logic                          mem_write_o,
   output bridge_pkg::addr_t             mem_addr_o,
   input  logic                          mem_ready_i
);
   import bridge_pkg::*;

   addr_t    dram_base;
   profile_t profile;
   data_t    oob_count;

   dram_access_if acc_bus ();

   host_csr_regs i_csr
   (
      .aclk_i          (aclk_i),
      .arst_n_i        (arst_n_i),
      .csr_req_valid_i (csr_req_valid_i),
      .csr_req_write_i (csr_req_write_i),
      .csr_req_addr_i  (csr_addr_e'(csr_req_addr_i)),
      .csr_req_wdata_i (csr_req_wdata_i),
      .profile_i       (profile),
      .oob_count_i     (oob_count),
      .csr_rsp_valid_o (csr_rsp_valid_o),
      .csr_rsp_rdata_o (csr_rsp_rdata_o),
      .core_reset_o    (core_reset_o),
      .dram_base_o     (dram_base)
   );

   // ARM to core direction
   host_window_xlate i_xlate
   (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .win_valid_i  (win_valid_i),
      .win_addr_i   (win_addr_i),
      .core_ready_i (core_ready_i),
      .win_ready_o  (win_ready_o),
      .core_valid_o (core_valid_o),
      .core_addr_o  (core_addr_o)
   );

   // core to ARM DRAM direction
   dram_rebase i_rebase
   (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .dram_valid_i (dram_valid_i),
      .dram_write_i (dram_write_i),
      .dram_addr_i  (dram_addr_i),
      .dram_base_i  (dram_base),
      .mem_ready_i  (mem_ready_i),
      .dram_ready_o (dram_ready_o),
      .mem_valid_o  (mem_valid_o),
      .mem_write_o  (mem_write_o),
      .mem_addr_o   (mem_addr_o),
      .acc_o        (acc_bus.src)
   );

   mem_profiler i_prof
   (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .core_reset_i (core_reset_o),
      .acc_i        (acc_bus.dst),
      .profile_o    (profile),
      .oob_count_o  (oob_count)
   );

endmodule

// ==== bench/bridge_chk.sv ====
module bridge_chk
(
   input logic              aclk_i,
   input logic              arst_n_i,
   input logic              csr_req_valid_i,
   input logic              csr_req_write_i,
   input logic              csr_rsp_valid_i,
   input logic              core_reset_i,
   input logic              core_valid_i,
   input logic              core_ready_i,
   input bridge_pkg::addr_t core_addr_i,
   input logic              mem_valid_i,
   input logic              mem_ready_i,
   input logic              mem_write_i,
   input bridge_pkg::addr_t mem_addr_i
);

   // the core stays held while the bridge is in reset
   reset_holds_core: assert property (@(posedge aclk_i) !arst_n_i |-> core_reset_i)
      else $error("core reset released while the bridge is in reset");

   core_stall_stable: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      core_valid_i && !core_ready_i |=> core_valid_i && $stable(core_addr_i))
      else $error("core request changed while stalled");

   mem_stall_stable: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i) && $stable(mem_write_i))
      else $error("ARM DRAM request changed while stalled");

   csr_read_latency: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      csr_req_valid_i && !csr_req_write_i |=> csr_rsp_valid_i)
      else $error("CSR read response missing one cycle after the request");

endmodule

// ==== bench/tb_tests.svh ====
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

task automatic csr_write(input logic [2:0] addr, input data_t data);
   @(posedge aclk);
   csr_req_valid <= 1'b1;
   csr_req_write <= 1'b1;
   csr_req_addr  <= addr;
   csr_req_wdata <= data;
   @(posedge aclk);
   csr_req_valid <= 1'b0;
   csr_req_write <= 1'b0;
endtask

task automatic csr_expect(input logic [2:0] addr, input data_t exp);
   int n;
   n = 0;
   @(posedge aclk);
   csr_req_valid <= 1'b1;
   csr_req_write <= 1'b0;
   csr_req_addr  <= addr;
   @(posedge aclk);
   csr_req_valid <= 1'b0;
   @(negedge aclk);
   while (!csr_rsp_valid && n < WAIT_LIMIT)
   begin
      n++;
      @(negedge aclk);
   end
   if (!csr_rsp_valid)
      note_failure($sformatf("no CSR read response for address %0d", addr));
   else
      check_value($sformatf("csr_rsp_rdata_o @%0d", addr), csr_rsp_rdata, exp);
endtask

// holds the request until the bridge takes it
task automatic win_send(input win_addr_t addr);
   int n;
   n = 0;
   @(posedge aclk);
   win_valid <= 1'b1;
   win_addr  <= addr;
   @(negedge aclk);
   while (!win_ready && n < WAIT_LIMIT)
   begin
      n++;
      @(negedge aclk);
   end
   if (!win_ready)
      note_failure("window request was never accepted");
   @(posedge aclk);
   win_valid <= 1'b0;
endtask

task automatic core_expect(input addr_t exp);
   int n;
   n = 0;
   @(negedge aclk);
   while (!core_valid && n < WAIT_LIMIT)
   begin
      n++;
      @(negedge aclk);
   end
   if (!core_valid)
      note_failure("no core request after a window transfer");
   else
      check_value("core_addr_o", core_addr, exp);
endtask

task automatic dram_send(input addr_t addr, input logic write);
   int n;
   n = 0;
   @(posedge aclk);
   dram_valid <= 1'b1;
   dram_write <= write;
   dram_addr  <= addr;
   @(negedge aclk);
   while (!dram_ready && n < WAIT_LIMIT)
   begin
      n++;
      @(negedge aclk);
   end
   if (!dram_ready)
      note_failure("DRAM request was never accepted");
   @(posedge aclk);
   dram_valid <= 1'b0;
endtask

task automatic mem_expect(input addr_t exp_addr, input logic exp_write);
   int n;
   n = 0;
   @(negedge aclk);
   while (!mem_valid && n < WAIT_LIMIT)
   begin
      n++;
      @(negedge aclk);
   end
   if (!mem_valid)
      note_failure("no ARM DRAM request after a core transfer");
   else
   begin
      check_value("mem_addr_o", mem_addr, exp_addr);
      check_value("mem_write_o", 32'(mem_write), 32'(exp_write));
   end
endtask

task automatic reset_state_test();
   @(negedge aclk);
   check_value("core_reset_o", 32'(core_reset), 32'd1);
   check_value("core_valid_o", 32'(core_valid), 32'd0);
   check_value("mem_valid_o", 32'(mem_valid), 32'd0);
   check_value("csr_rsp_valid_o", 32'(csr_rsp_valid), 32'd0);
   csr_expect(csr_dram_base, 32'd0);
   csr_expect(csr_prof0, 32'd0);
   csr_expect(csr_prof1, 32'd0);
   csr_expect(csr_prof2, 32'd0);
   csr_expect(csr_prof3, 32'd0);
   csr_expect(csr_oob_count, 32'd0);
   finish_test("reset state");
endtask

task automatic csr_access_test();
   data_t base;
   base = $urandom();
   csr_write(csr_dram_base, base);
   csr_expect(csr_dram_base, base);
   @(negedge aclk);
   check_value("core_reset_o", 32'(core_reset), 32'd1);
   csr_write(csr_ctrl, 32'd1);
   @(negedge aclk);
   check_value("core_reset_o", 32'(core_reset), 32'd0);
   // read-only and unmapped words ignore writes
   csr_write(csr_prof0, 32'hffff_ffff);
   csr_write(3'd7, 32'h1234_5678);
   csr_expect(csr_prof0, 32'd0);
   csr_expect(3'd7, 32'd0);
   csr_expect(csr_dram_base, base);
   finish_test("csr access");
endtask

task automatic window_xlate_test();
   logic [27:0] off;
   addr_t       exp_a;
   addr_t       exp_b;
   for (int i = 0; i < 8; i++)
   begin
      off = 28'($urandom());
      if (i % 2 == 0)
      begin
         win_send({2'b00, off});
         core_expect({4'h8, off});
      end
      else
      begin
         win_send({2'b10, off});
         core_expect({4'h0, off});
      end
   end

   // stall the core side with a second request waiting behind the first
   off   = 28'($urandom());
   exp_a = {4'h8, off};
   exp_b = {4'h0, ~off};
   @(posedge aclk);
   core_ready <= 1'b0;
   win_send({2'b00, off});
   @(posedge aclk);
   win_valid <= 1'b1;
   win_addr  <= {2'b10, ~off};
   repeat (4)
   begin
      @(negedge aclk);
      check_value("core_valid_o", 32'(core_valid), 32'd1);
      check_value("core_addr_o", core_addr, exp_a);
      check_value("win_ready_o", 32'(win_ready), 32'd0);
   end
   @(posedge aclk);
   core_ready <= 1'b1;
   // first item leaves and the waiting one is taken on this edge
   @(posedge aclk);
   win_valid <= 1'b0;
   core_expect(exp_b);
   finish_test("window translation");
endtask

task automatic dram_rebase_test();
   addr_t base;
   base = 32'h1000_0000;
   csr_write(csr_ctrl, 32'd0);
   csr_write(csr_ctrl, 32'd1);
   csr_write(csr_dram_base, base);
   dram_send(32'h8000_0100, 1'b1);
   mem_expect(32'h1000_0100, 1'b1);
   dram_send(32'h8000_0100, 1'b0);
   mem_expect(32'h1000_0100, 1'b0);

   @(posedge aclk);
   mem_ready <= 1'b0;
   dram_send(32'h8012_3440, 1'b1);
   repeat (4)
   begin
      @(negedge aclk);
      check_value("mem_valid_o", 32'(mem_valid), 32'd1);
      check_value("mem_addr_o", mem_addr, 32'h1012_3440);
      check_value("mem_write_o", 32'(mem_write), 32'd1);
      check_value("dram_ready_o", 32'(dram_ready), 32'd0);
   end
   @(posedge aclk);
   mem_ready <= 1'b1;

   // exactly 120 MiB past the core DRAM base
   dram_send(32'h8780_0000, 1'b0);
   mem_expect(32'h1780_0000, 1'b0);
   csr_expect(csr_oob_count, 32'd1);
   finish_test("dram rebase");
endtask

task automatic profiler_test();
   csr_write(csr_ctrl, 32'd0);
   csr_write(csr_ctrl, 32'd1);
   dram_send(32'h8000_0000, 1'b0);
   dram_send(32'h8080_0000, 1'b1);
   dram_send(32'hbf80_0000, 1'b0);
   // regions 0, 1 and 127; only the last lies beyond the limit
   csr_expect(csr_prof0, 32'h0000_0003);
   csr_expect(csr_prof1, 32'd0);
   csr_expect(csr_prof2, 32'd0);
   csr_expect(csr_prof3, 32'h8000_0000);
   csr_expect(csr_oob_count, 32'd1);
   csr_write(csr_ctrl, 32'd0);
   csr_write(csr_ctrl, 32'd1);
   csr_expect(csr_prof0, 32'd0);
   csr_expect(csr_prof3, 32'd0);
   csr_expect(csr_oob_count, 32'd0);
   finish_test("profiler");
endtask

`endif

// ==== bench/tb_zynq_host_bridge.sv ====
module tb_zynq_host_bridge;
   import bridge_pkg::*;

   localparam int NUM_TESTS = 5;
   // upper bound on the length of one directed test
   localparam int TEST_TIME = 2000;
   // cycles to wait for a handshake before giving up
   localparam int WAIT_LIMIT = 20;

   logic       aclk;
   logic       arst_n;
   logic       csr_req_valid;
   logic       csr_req_write;
   logic [2:0] csr_req_addr;
   data_t      csr_req_wdata;
   logic       csr_rsp_valid;
   data_t      csr_rsp_rdata;
   logic       core_reset;
   logic       win_valid;
   win_addr_t  win_addr;
   logic       win_ready;
   logic       core_valid;
   addr_t      core_addr;
   logic       core_ready;
   logic       dram_valid;
   logic       dram_write;
   addr_t      dram_addr;
   logic       dram_ready;
   logic       mem_valid;
   logic       mem_write;
   addr_t      mem_addr;
   logic       mem_ready;

   int err_count;
   int test_errs;
   int test_count;

   zynq_host_bridge i_dut
   (
      .aclk_i          (aclk),
      .arst_n_i        (arst_n),
      .csr_req_valid_i (csr_req_valid),
      .csr_req_write_i (csr_req_write),
      .csr_req_addr_i  (csr_req_addr),
      .csr_req_wdata_i (csr_req_wdata),
      .csr_rsp_valid_o (csr_rsp_valid),
      .csr_rsp_rdata_o (csr_rsp_rdata),
      .core_reset_o    (core_reset),
      .win_valid_i     (win_valid),
      .win_addr_i      (win_addr),
      .win_ready_o     (win_ready),
      .core_valid_o    (core_valid),
      .core_addr_o     (core_addr),
      .core_ready_i    (core_ready),
      .dram_valid_i    (dram_valid),
      .dram_write_i    (dram_write),
      .dram_addr_i     (dram_addr),
      .dram_ready_o    (dram_ready),
      .mem_valid_o     (mem_valid),
      .mem_write_o     (mem_write),
      .mem_addr_o      (mem_addr),
      .mem_ready_i     (mem_ready)
   );

   bind zynq_host_bridge bridge_chk i_chk
   (
      .aclk_i          (aclk_i),
      .arst_n_i        (arst_n_i),
      .csr_req_valid_i (csr_req_valid_i),
      .csr_req_write_i (csr_req_write_i),
      .csr_rsp_valid_i (csr_rsp_valid_o),
      .core_reset_i    (core_reset_o),
      .core_valid_i    (core_valid_o),
      .core_ready_i    (core_ready_i),
      .core_addr_i     (core_addr_o),
      .mem_valid_i     (mem_valid_o),
      .mem_ready_i     (mem_ready_i),
      .mem_write_i     (mem_write_o),
      .mem_addr_i      (mem_addr_o)
   );

   initial
   begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
         err_count++;
         test_errs++;
      end
   endtask

   task automatic note_failure(input string what);
      $display("%s", what);
      err_count++;
      test_errs++;
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, test_errs);
      test_count++;
      test_errs = 0;
   endtask

   `include "tb_tests.svh"

   initial
   begin
      void'($urandom(32'ha0b6_50db));
      err_count  = 0;
      test_errs  = 0;
      test_count = 0;
      arst_n        <= 1'b0;
      csr_req_valid <= 1'b0;
      csr_req_write <= 1'b0;
      csr_req_addr  <= 3'd0;
      csr_req_wdata <= '0;
      win_valid     <= 1'b0;
      win_addr      <= '0;
      core_ready    <= 1'b1;
      dram_valid    <= 1'b0;
      dram_write    <= 1'b0;
      dram_addr     <= '0;
      mem_ready     <= 1'b1;
      repeat (3) @(posedge aclk);
      arst_n <= 1'b1;

      reset_state_test();
      csr_access_test();
      window_xlate_test();
      dram_rebase_test();
      profiler_test();

      $display("%0d tests run, %0d errors", test_count, err_count);
      if (err_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // stops a run that hangs on a handshake that never completes
   initial
   begin
      #(NUM_TESTS * TEST_TIME);
      $display("watchdog expired before the tests finished");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+design
+incdir+bench
design/bridge_pkg.sv
design/dram_access_if.sv
design/host_csr_regs.sv
design/host_window_xlate.sv
design/dram_rebase.sv
design/mem_profiler.sv
design/zynq_host_bridge.sv
bench/bridge_chk.sv
bench/tb_zynq_host_bridge.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_zynq_host_bridge
FILELIST = compile.f

SOURCES  = $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS  = $(wildcard design/*.svh bench/*.svh)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
